// File: Makefile
TOP := lc3_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f lc3_core.f --top-module $(TOP) -o lc3_sim

run: build
	@out="$$(./obj_dir/lc3_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

lint:
	verilator --lint-only --timing -f lc3_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: lc3_core.f
src/lc3_pkg.sv
src/lc3_regfile.sv
src/lc3_alu.sv
src/lc3_addr_gen.sv
src/lc3_control.sv
src/lc3_core.sv
test/tb_clock.sv
test/lc3_mem_model.sv
test/lc3_tb.sv

// File: src/lc3_addr_gen.sv
`timescale 1ns/1ps

module lc3_addr_gen (
    input  lc3_pkg::instr_u ir,
    input  lc3_pkg::word_t  pc,
    input  lc3_pkg::word_t  base,
    input  lc3_pkg::cc_t    cc,
    output lc3_pkg::word_t  target,
    output logic            branch_taken
);
    import lc3_pkg::*;

    word_t off9;
    word_t off11;
    word_t off6;

    // sign extension of the three offset fields
    assign off9  = {{7{ir.br.offset9[8]}}, ir.br.offset9};
    assign off11 = {{5{ir.jsr.offset11[10]}}, ir.jsr.offset11};
    assign off6  = {{10{ir.mem.offset6[5]}}, ir.mem.offset6};

    ////////////////////////////////////////
    // target select
    ////////////////////////////////////////
    // pc here is already past the current instruction
    always_comb begin
        case (ir.opr.opcode)
            // jsr vs jsrr by bit 11
            OP_JSR:         target = ir.jsr.long_flag ? pc + off11 : base;
            // jmp and ret
            OP_JMP:         target = base;
            OP_LDR, OP_STR: target = base + off6;
            // br, ld, lea, st
            default:        target = pc + off9;
        endcase
    end

    // nzp = 000 never branches
    assign branch_taken = (ir.br.n & cc.n) | (ir.br.z & cc.z) | (ir.br.p & cc.p);

endmodule

// File: src/lc3_alu.sv
`timescale 1ns/1ps

module lc3_alu (
    input  lc3_pkg::alu_op_e op,
    input  lc3_pkg::word_t   a,
    input  lc3_pkg::word_t   b,
    output lc3_pkg::word_t   result,
    output lc3_pkg::cc_t     cc
);
    import lc3_pkg::*;

    ////////////////////////////////////////
    // operation select
    ////////////////////////////////////////
    always_comb begin
        case (op)
            // 16-bit wrap, no carry out
            ALU_ADD: result = a + b;
            ALU_AND: result = a & b;
            // not ignores b
            ALU_NOT: result = ~a;
            // lea address and load data come through here
            default: result = a;
        endcase
    end

    ////////////////////////////////////////
    // condition codes
    ////////////////////////////////////////
    // exactly one of n/z/p is set for any result
    always_comb begin
        cc.n = result[WORD_W-1];
        cc.z = (result == '0);
        // positive means neither sign nor zero
        cc.p = ~cc.n & ~cc.z;
    end

endmodule

// File: src/lc3_control.sv
`timescale 1ns/1ps

module lc3_control #(
    parameter lc3_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic              clk,
    input  logic              reset,
    // memory port
    output lc3_pkg::mem_req_t mem_req,
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  lc3_pkg::word_t    mem_rsp_data,
    // register file
    output lc3_pkg::reg_idx_t rf_rd_idx_a,
    output lc3_pkg::reg_idx_t rf_rd_idx_b,
    input  lc3_pkg::word_t    rf_rd_data_a,
    input  lc3_pkg::word_t    rf_rd_data_b,
    output logic              rf_wr_en,
    output lc3_pkg::reg_idx_t rf_wr_idx,
    output lc3_pkg::word_t    rf_wr_data,
    // alu
    output lc3_pkg::alu_op_e  alu_op,
    output lc3_pkg::word_t    alu_a,
    output lc3_pkg::word_t    alu_b,
    input  lc3_pkg::word_t    alu_result,
    input  lc3_pkg::cc_t      alu_cc,
    // address generator
    output lc3_pkg::instr_u   ir,
    output lc3_pkg::word_t    pc,
    output lc3_pkg::cc_t      cc,
    input  lc3_pkg::word_t    target,
    input  logic              branch_taken
);
    import lc3_pkg::*;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_WAIT,
        DECODE,
        EXEC,
        MEM_REQ,
        MEM_WAIT,
        WRITEBACK
    } state_e;

    state_e state;
    // low only for the cycle out of reset
    logic started;
    word_t mem_addr;
    word_t st_data;
    word_t ld_data;
    opcode_e opcode;
    logic is_store;
    word_t imm5_ext;

    assign opcode   = ir.opr.opcode;
    assign is_store = (opcode == OP_ST) || (opcode == OP_STR);
    assign imm5_ext = {{11{ir.opr.imm5[4]}}, ir.opr.imm5};

    ////////////////////////////////////////
    // memory request
    ////////////////////////////////////////
    // pc and mem_addr only move on acceptance, so the request holds
    assign mem_req_valid   = started && (state == FETCH_REQ || state == MEM_REQ);
    assign mem_req.write   = (state == MEM_REQ) && is_store;
    assign mem_req.address = (state == MEM_REQ) ? mem_addr : pc;
    assign mem_req.wdata   = st_data;

    ////////////////////////////////////////
    // datapath steering
    ////////////////////////////////////////
    // sr1 and base share bits 8:6
    assign rf_rd_idx_a = ir.opr.sr1;
    // store source sits in the dr field
    assign rf_rd_idx_b = is_store ? ir.mem.dr : ir.opr.imm5[2:0];

    always_comb begin
        case (opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_AND:  alu_op = ALU_AND;
            OP_NOT:  alu_op = ALU_NOT;
            default: alu_op = ALU_PASS;
        endcase
        // load data and lea pass through the alu for their flags
        if (state == WRITEBACK) begin
            alu_a = ld_data;
        end else if (opcode == OP_LEA) begin
            alu_a = target;
        end else begin
            alu_a = rf_rd_data_a;
        end
        alu_b = ir.opr.imm ? imm5_ext : rf_rd_data_b;
    end

    // jsr links the incremented pc into r7
    assign rf_wr_idx  = (opcode == OP_JSR) ? LINK_REG : ir.opr.dr;
    assign rf_wr_data = (opcode == OP_JSR) ? pc : alu_result;
    assign rf_wr_en   = (state == WRITEBACK) ||
                        ((state == EXEC) &&
                         (opcode inside {OP_ADD, OP_AND, OP_NOT, OP_LEA, OP_JSR}));

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH_REQ;
            started <= 1'b0;
            pc      <= RESET_PC;
            cc      <= '{n: 1'b0, z: 1'b1, p: 1'b0};
        end else begin
            started <= 1'b1;
            case (state)
                FETCH_REQ: begin
                    if (mem_req_valid && mem_req_ready) begin
                        pc    <= pc + 16'd1;
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (mem_rsp_valid) begin
                        ir    <= mem_rsp_data;
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    // rti, reserved and dropped opcodes fall out as no-ops
                    if (opcode inside {OP_ADD, OP_AND, OP_NOT, OP_BR, OP_JMP, OP_JSR,
                                       OP_LD, OP_LDR, OP_LEA, OP_ST, OP_STR}) begin
                        state <= EXEC;
                    end else begin
                        state <= FETCH_REQ;
                    end
                end
                EXEC: begin
                    state <= FETCH_REQ;
                    case (opcode)
                        OP_ADD, OP_AND, OP_NOT, OP_LEA: cc <= alu_cc;
                        OP_BR: begin
                            if (branch_taken) begin
                                pc <= target;
                            end
                        end
                        // link write lands on this same edge
                        OP_JMP, OP_JSR: pc <= target;
                        OP_LD, OP_LDR, OP_ST, OP_STR: begin
                            mem_addr <= target;
                            st_data  <= rf_rd_data_b;
                            state    <= MEM_REQ;
                        end
                        default: ;
                    endcase
                end
                MEM_REQ: begin
                    // a write is done once accepted
                    if (mem_req_ready) begin
                        state <= is_store ? FETCH_REQ : MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (mem_rsp_valid) begin
                        ld_data <= mem_rsp_data;
                        state   <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    cc    <= alu_cc;
                    state <= FETCH_REQ;
                end
                default: state <= FETCH_REQ;
            endcase
        end
    end

endmodule

// File: src/lc3_core.sv
`timescale 1ns/1ps

module lc3_core #(
    parameter lc3_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic              clk,
    input  logic              reset,
    output lc3_pkg::mem_req_t mem_req,
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  lc3_pkg::word_t    mem_rsp_data
);
    import lc3_pkg::*;

    // register file
    reg_idx_t rf_rd_idx_a;
    reg_idx_t rf_rd_idx_b;
    word_t rf_rd_data_a;
    word_t rf_rd_data_b;
    logic rf_wr_en;
    reg_idx_t rf_wr_idx;
    word_t rf_wr_data;
    // alu
    alu_op_e alu_op;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    cc_t alu_cc;
    // address generation
    instr_u ir;
    word_t pc;
    cc_t cc;
    word_t target;
    logic branch_taken;

    ////////////////////////////////////////
    // sequencing and memory port
    ////////////////////////////////////////
    lc3_control #(
        .RESET_PC(RESET_PC)
    ) u_control (
        .*
    );

    lc3_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_a  (rf_rd_idx_a),
        .rd_idx_b  (rf_rd_idx_b),
        .rd_data_a (rf_rd_data_a),
        .rd_data_b (rf_rd_data_b),
        .wr_en     (rf_wr_en),
        .wr_idx    (rf_wr_idx),
        .wr_data   (rf_wr_data)
    );

    lc3_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .cc     (alu_cc)
    );

    // base register comes off read port a
    lc3_addr_gen u_addr_gen (
        .ir           (ir),
        .pc           (pc),
        .base         (rf_rd_data_a),
        .cc           (cc),
        .target       (target),
        .branch_taken (branch_taken)
    );

endmodule

// File: src/lc3_pkg.sv
package lc3_pkg;

    ////////////////////////////////////////
    // widths and basic types
    ////////////////////////////////////////
    localparam int WORD_W = 16;
    localparam int REG_COUNT = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [2:0] reg_idx_t;

    // jsr and jsrr always link through r7
    localparam reg_idx_t LINK_REG = 3'd7;

    // jmp also covers ret (base r7)
    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_JSR = 4'b0100,
        OP_AND = 4'b0101,
        OP_LDR = 4'b0110,
        OP_STR = 4'b0111,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_e;

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////
    // add/and/not; with imm clear, imm5[2:0] is sr2
    typedef struct packed {
        opcode_e opcode;
        reg_idx_t dr;
        reg_idx_t sr1;
        logic imm;
        logic [4:0] imm5;
    } opr_fmt_t;

    typedef struct packed {
        opcode_e opcode;
        logic n;
        logic z;
        logic p;
        logic [8:0] offset9;
    } br_fmt_t;

    // ld/st/lea read offset9 from the same low nine bits
    typedef struct packed {
        opcode_e opcode;
        reg_idx_t dr;
        reg_idx_t base;
        logic [5:0] offset6;
    } mem_fmt_t;

    typedef struct packed {
        opcode_e opcode;
        logic long_flag;
        logic [10:0] offset11;
    } jsr_fmt_t;

    typedef union packed {
        opr_fmt_t opr;
        br_fmt_t br;
        mem_fmt_t mem;
        jsr_fmt_t jsr;
    } instr_u;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } cc_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_AND,
        ALU_NOT,
        ALU_PASS
    } alu_op_e;

    typedef struct packed {
        logic write;
        word_t address;
        word_t wdata;
    } mem_req_t;

endpackage

// File: src/lc3_regfile.sv
`timescale 1ns/1ps

module lc3_regfile (
    input  logic              clk,
    input  logic              reset,
    input  lc3_pkg::reg_idx_t rd_idx_a,
    input  lc3_pkg::reg_idx_t rd_idx_b,
    output lc3_pkg::word_t    rd_data_a,
    output lc3_pkg::word_t    rd_data_b,
    input  logic              wr_en,
    input  lc3_pkg::reg_idx_t wr_idx,
    input  lc3_pkg::word_t    wr_data
);
    import lc3_pkg::*;

    // r0..r7
    word_t regs [REG_COUNT];

    // read ports are combinational, so a write shows up the cycle after
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    ////////////////////////////////////////
    // single write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            // every register starts at zero
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: test/lc3_mem_model.sv
`timescale 1ns/1ps

module lc3_mem_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_en,
    input  lc3_pkg::mem_req_t mem_req,
    input  logic              mem_req_valid,
    output logic              mem_req_ready,
    output logic              mem_rsp_valid,
    output lc3_pkg::word_t    mem_rsp_data
);
    import lc3_pkg::*;

    localparam int DEPTH = 65536;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    word_t mem [DEPTH];
    logic [15:0] lfsr = 16'd51;
    logic pending;
    logic take;
    int delay;
    int draw;
    word_t rd_word;
    mem_req_t req;

    // galois form, shift right
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        pending = 1'b0;
        delay = 0;
    end

    ////////////////////////////////////////
    // sample at the edge, drive 1 ns later
    ////////////////////////////////////////
    always @(posedge clk) begin
        take = mem_req_valid && mem_req_ready;
        req = mem_req;
        #1;
        mem_rsp_valid = 1'b0;
        if (reset) begin
            pending = 1'b0;
        end else if (take) begin
            if (req.write) begin
                mem[req.address] = req.wdata;
            end else begin
                pending = 1'b1;
                rd_word = mem[req.address];
                // 0..3 extra cycles under stalls
                if (stall_en) draw_bits(2, delay);
                else delay = 0;
            end
        end
        if (pending) begin
            if (delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = rd_word;
                pending = 1'b0;
            end else begin
                delay--;
            end
        end
        // ready one cycle in four when stalling
        if (stall_en) begin
            draw_bits(2, draw);
            mem_req_ready = (draw == 0);
        end else begin
            mem_req_ready = 1'b1;
        end
    end

endmodule

// File: test/lc3_tb.sv
`timescale 1ns/1ps

module lc3_tb;
    import lc3_pkg::*;

    localparam word_t START = 16'h3000;
    localparam int N_TESTS = 5;
    localparam int MAX_CYCLES = 3000;
    localparam int WATCHDOG_NS = N_TESTS * (MAX_CYCLES + 16) * 20;

    logic clk;
    logic reset;
    logic restart;
    logic stall_en;
    mem_req_t mem_req;
    logic mem_req_valid;
    logic mem_req_ready;
    logic mem_rsp_valid;
    word_t mem_rsp_data;

    // accepted stores, and the unstalled alu run kept for comparison
    word_t st_addr [$];
    word_t st_data [$];
    word_t ref_addr [$];
    word_t ref_data [$];
    word_t load_addr;
    int test_errors;
    int total_errors;
    int tests_failed;
    int unstable;
    logic held_valid;
    mem_req_t held_req;

    tb_clock clk0 (
        .clk     (clk),
        .reset   (reset),
        .restart (restart)
    );

    lc3_core #(
        .RESET_PC(START)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    lc3_mem_model mem0 (
        .clk           (clk),
        .reset         (reset),
        .stall_en      (stall_en),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    ////////////////////////////////////////
    // port monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            // a stalled request must come back unchanged
            if (held_valid && (!mem_req_valid || mem_req != held_req)) unstable++;
            held_valid = mem_req_valid && !mem_req_ready;
            held_req = mem_req;
            if (mem_req_valid && mem_req_ready && mem_req.write) begin
                st_addr.push_back(mem_req.address);
                st_data.push_back(mem_req.wdata);
            end
        end
    end

    ////////////////////////////////////////
    // isa helpers and assembler
    ////////////////////////////////////////
    function automatic word_t sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    // n on sign, z on zero, p otherwise
    function automatic cc_t flags_of(input word_t v);
        cc_t f;
        f.n = v[15];
        f.z = (v == 16'd0);
        f.p = !f.n && !f.z;
        return f;
    endfunction

    // offsets count from the word after the instruction
    function automatic word_t rel(input word_t tgt);
        return tgt - (load_addr + 16'd1);
    endfunction

    function automatic word_t op_rr(opcode_e op, reg_idx_t dr, reg_idx_t sa, reg_idx_t sb);
        return {op, dr, sa, 3'b000, sb};
    endfunction

    function automatic word_t op_ri(opcode_e op, reg_idx_t dr, reg_idx_t sa, logic [4:0] imm);
        return {op, dr, sa, 1'b1, imm};
    endfunction

    function automatic word_t op_not(reg_idx_t dr, reg_idx_t sa);
        return {OP_NOT, dr, sa, 6'b111111};
    endfunction

    function automatic word_t op_br(logic n, logic z, logic p, word_t tgt);
        word_t off;
        off = rel(tgt);
        return {OP_BR, n, z, p, off[8:0]};
    endfunction

    // ld, st, lea
    function automatic word_t op_pc(opcode_e op, reg_idx_t r, word_t tgt);
        word_t off;
        off = rel(tgt);
        return {op, r, off[8:0]};
    endfunction

    function automatic word_t op_base(opcode_e op, reg_idx_t r, reg_idx_t b, logic [5:0] off);
        return {op, r, b, off};
    endfunction

    function automatic word_t op_jsr(word_t tgt);
        word_t off;
        off = rel(tgt);
        return {OP_JSR, 1'b1, off[10:0]};
    endfunction

    task automatic emit(input word_t w);
        mem0.mem[load_addr] = w;
        load_addr = load_addr + 16'd1;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem0.mem[i] = word_t'(i) ^ 16'hC35A;
        end
        load_addr = START;
    endtask

    // taken stores r0 to the even slot, fall-through to the odd one
    function automatic word_t slot(input int i, input logic taken);
        return 16'h3100 + word_t'(2 * i) + (taken ? 16'd0 : 16'd1);
    endfunction

    task automatic branch_block(input int i, input logic n, input logic z, input logic p);
        emit(op_br(n, z, p, load_addr + 16'd3));
        emit(op_pc(OP_ST, 3'd0, slot(i, 1'b0)));
        emit(op_br(1'b1, 1'b1, 1'b1, load_addr + 16'd2));
        emit(op_pc(OP_ST, 3'd0, slot(i, 1'b1)));
    endtask

    ////////////////////////////////////////
    // run and check
    ////////////////////////////////////////
    task automatic run_program(input int n, input logic stalls);
        test_errors = 0;
        stall_en = stalls;
        // self loop at the end
        emit(op_br(1'b1, 1'b1, 1'b1, load_addr));
        restart = ~restart;
        wait (reset);
        st_addr.delete();
        st_data.delete();
        unstable = 0;
        wait (!reset);
        while (st_addr.size() < n) @(posedge clk);
    endtask

    task automatic check_store(input int i, input word_t a, input word_t d);
        if (st_addr[i] != a || st_data[i] != d) begin
            $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, i, st_data[i], st_addr[i], d, a);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%-8s %0d stores, %0d errors", name, st_addr.size(), test_errors);
        total_errors += test_errors;
        if (test_errors != 0) tests_failed++;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_alu(input logic stalls, input string name);
        word_t r [1:6];
        fill_memory();
        emit(op_ri(OP_ADD, 3'd1, 3'd0, 5'd7));
        emit(op_ri(OP_ADD, 3'd2, 3'd0, 5'h1D));
        emit(op_rr(OP_ADD, 3'd3, 3'd1, 3'd2));
        emit(op_rr(OP_AND, 3'd4, 3'd1, 3'd2));
        emit(op_ri(OP_AND, 3'd5, 3'd2, 5'h1A));
        emit(op_not(3'd6, 3'd2));
        for (int k = 1; k <= 6; k++) begin
            emit(op_pc(OP_ST, reg_idx_t'(k), 16'h3020 + word_t'(k - 1)));
        end
        run_program(6, stalls);
        r[1] = sext5(5'd7);
        r[2] = sext5(5'h1D);
        r[3] = r[1] + r[2];
        r[4] = r[1] & r[2];
        r[5] = r[2] & sext5(5'h1A);
        r[6] = ~r[2];
        for (int k = 1; k <= 6; k++) begin
            check_store(k - 1, 16'h3020 + word_t'(k - 1), r[k]);
        end
        if (!stalls) begin
            ref_addr = st_addr;
            ref_data = st_data;
        end else begin
            if (unstable != 0) begin
                $display("request changed %0d times while ready was low", unstable);
                test_errors++;
            end
            for (int k = 0; k < st_addr.size() && k < ref_addr.size(); k++) begin
                if (st_addr[k] != ref_addr[k] || st_data[k] != ref_data[k]) begin
                    $display("** Error at %0t: stalled store %0d differs", $time, k);
                    test_errors++;
                end
            end
        end
        finish_test(name);
    endtask

    task automatic test_branch();
        cc_t f;
        logic taken [10];
        int i;
        fill_memory();
        // flags after reset are z
        branch_block(0, 1'b0, 1'b1, 1'b0);
        taken[0] = 1'b1;
        i = 1;
        for (int v = -1; v <= 1; v++) begin
            for (int c = 0; c < 3; c++) begin
                emit(op_ri(OP_ADD, 3'd1, 3'd0, 5'(v)));
                branch_block(i, c == 0, c == 1, c == 2);
                f = flags_of(sext5(5'(v)));
                taken[i] = (c == 0 && f.n) || (c == 1 && f.z) || (c == 2 && f.p);
                i++;
            end
        end
        run_program(10, 1'b0);
        for (int k = 0; k < 10; k++) begin
            check_store(k, slot(k, taken[k]), 16'd0);
        end
        finish_test("branch");
    endtask

    task automatic test_jsr();
        localparam word_t S = 16'h3040;
        word_t jsr_at;
        word_t jsrr_at;
        word_t tail;
        fill_memory();
        jsr_at = load_addr;
        emit(op_jsr(16'h3010));
        emit(op_pc(OP_ST, 3'd2, S + 16'd1));
        emit(op_pc(OP_LEA, 3'd3, 16'h3014));
        jsrr_at = load_addr;
        emit({OP_JSR, 1'b0, 2'b00, 3'd3, 6'd0});
        emit(op_pc(OP_ST, 3'd2, S + 16'd3));
        tail = load_addr + 16'd3;
        emit(op_pc(OP_LEA, 3'd4, tail));
        emit(op_base(OP_JMP, 3'd0, 3'd4, 6'd0));
        // skipped by the jmp
        emit(op_pc(OP_ST, 3'd0, S + 16'd7));
        emit(op_pc(OP_ST, 3'd4, S + 16'd4));
        emit(op_br(1'b1, 1'b1, 1'b1, load_addr));
        // subroutines, each returns through r7
        load_addr = 16'h3010;
        emit(op_pc(OP_ST, 3'd7, S));
        emit(op_ri(OP_ADD, 3'd2, 3'd0, 5'd9));
        emit(op_base(OP_JMP, 3'd0, 3'd7, 6'd0));
        load_addr = 16'h3014;
        emit(op_pc(OP_ST, 3'd7, S + 16'd2));
        emit(op_ri(OP_ADD, 3'd2, 3'd0, 5'd4));
        emit(op_base(OP_JMP, 3'd0, 3'd7, 6'd0));
        run_program(5, 1'b0);
        check_store(0, S, jsr_at + 16'd1);
        check_store(1, S + 16'd1, sext5(5'd9));
        check_store(2, S + 16'd2, jsrr_at + 16'd1);
        check_store(3, S + 16'd3, sext5(5'd4));
        check_store(4, S + 16'd4, tail);
        finish_test("jsr");
    endtask

    task automatic test_load();
        localparam word_t D = 16'h3040;
        localparam word_t R = 16'h3060;
        word_t d [3];
        cc_t f;
        fill_memory();
        d[0] = 16'h8123;
        d[1] = 16'h0000;
        d[2] = 16'h1234;
        emit(op_pc(OP_LEA, 3'd2, D));
        emit(op_base(OP_LDR, 3'd3, 3'd2, 6'd1));
        branch_block(0, 1'b0, 1'b1, 1'b0);
        emit(op_pc(OP_LD, 3'd1, D));
        branch_block(1, 1'b1, 1'b0, 1'b0);
        emit(op_base(OP_LDR, 3'd4, 3'd2, 6'd2));
        emit(op_pc(OP_ST, 3'd1, R));
        emit(op_base(OP_STR, 3'd4, 3'd2, 6'd8));
        emit(op_pc(OP_ST, 3'd2, R + 16'd1));
        for (int k = 0; k < 3; k++) begin
            mem0.mem[D + word_t'(k)] = d[k];
        end
        run_program(5, 1'b0);
        f = flags_of(d[1]);
        check_store(0, slot(0, f.z), 16'd0);
        f = flags_of(d[0]);
        check_store(1, slot(1, f.n), 16'd0);
        check_store(2, R, d[0]);
        check_store(3, D + 16'd8, d[2]);
        check_store(4, R + 16'd1, D);
        finish_test("load");
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        restart = 1'b0;
        stall_en = 1'b0;
        total_errors = 0;
        tests_failed = 0;
        test_alu(1'b0, "alu");
        test_branch();
        test_jsr();
        test_load();
        test_alu(1'b1, "stall");
        $display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // bound is tests times cycle budget
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset,
    input  logic restart
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset on at start, then again on every toggle of restart
    initial begin
        reset = 1'b1;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1 reset = 1'b0;
            @(restart);
            @(posedge clk);
            #1 reset = 1'b1;
        end
    end

endmodule
